//--- mem_pipe.f
+incdir+include
+incdir+testbench
src/mem_op_pkg.sv
src/tlb_pkg.sv
src/tlb_bus_if.sv
src/mem_agen.sv
src/dtlb_fill_ctrl.sv
src/dtlb_entry.sv
src/dtlb_match_sel.sv
src/mem_except_stage.sv
src/mem_pipe_top.sv
testbench/tb_mem_pipe.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns \
  --top-module tb_mem_pipe -f mem_pipe.f -o Vtb_mem_pipe

sim_out="$(./obj_dir/Vtb_mem_pipe 2>&1 || true)"
echo "$sim_out"

if grep -qx "Regression passed" <<< "$sim_out"; then
  exit 0
fi
exit 1

//--- testbench/mem_pipe_model.svh
`ifndef MEM_PIPE_MODEL_SVH
`define MEM_PIPE_MODEL_SVH

// Reference copy of the data TLB
logic                 m_valid [`MEM_DTLB_ELS];
tlb_pkg::tlb_entry_s  m_entry [`MEM_DTLB_ELS];
int                   m_victim;

// Predicted result of the request in flight
logic                       exp_early, exp_ld_miss, exp_st_miss;
logic                       exp_ld_mis, exp_st_mis, exp_ld_pf, exp_st_pf;
logic                       exp_ptag_chk;
logic [`MEM_PTAG_WIDTH-1:0] exp_ptag;

task automatic model_reset();
  for (int i = 0; i < `MEM_DTLB_ELS; i++)
    m_valid[i] = 1'b0;
  m_victim     = 0;
  exp_early    = 1'b0;
  exp_ld_miss  = 1'b0;
  exp_st_miss  = 1'b0;
  exp_ld_mis   = 1'b0;
  exp_st_mis   = 1'b0;
  exp_ld_pf    = 1'b0;
  exp_st_pf    = 1'b0;
  exp_ptag_chk = 1'b0;
  exp_ptag     = '0;
endtask

// Bytes touched by one access
function automatic int access_bytes(input mem_op_e op);
  case (op)
    e_op_lb, e_op_lbu, e_op_sb: return 1;
    e_op_lh, e_op_lhu, e_op_sh: return 2;
    e_op_lw, e_op_lwu, e_op_sw: return 4;
    default:                    return 8;
  endcase
endfunction

task automatic model_predict(input logic req_v, input mem_op_e op,
                             input logic [`MEM_VADDR_WIDTH-1:0] vaddr,
                             input logic trans, input logic user);
  logic [`MEM_VTAG_WIDTH-1:0] vtag;
  logic                       hit, load, store, mis, fault;
  pte_leaf_s                  pte;
  vtag = vaddr[`MEM_VADDR_WIDTH-1:`MEM_PAGE_OFFSET_WIDTH];
  hit  = 1'b0;
  pte  = '0;
  // First matching way in index order
  for (int i = 0; i < `MEM_DTLB_ELS; i++)
  begin
    if (!hit && m_valid[i] && m_entry[i].vtag == vtag)
    begin
      hit = 1'b1;
      pte = m_entry[i].pte;
    end
  end
  load  = req_v && (op <= e_op_ld);
  store = req_v && (op > e_op_ld);
  mis   = (int'(vaddr[2:0]) % access_bytes(op)) != 0;
  if (!pte.a)
    fault = 1'b1;
  else if ((user && !pte.u) || (!user && pte.u))
    fault = 1'b1;
  else if (load)
    fault = !pte.r;
  else
    fault = !pte.w || !pte.d;
  exp_early    = req_v;
  exp_ld_mis   = load && mis;
  exp_st_mis   = store && mis;
  exp_ld_miss  = load && !mis && trans && !hit;
  exp_st_miss  = store && !mis && trans && !hit;
  exp_ld_pf    = load && !mis && trans && hit && fault;
  exp_st_pf    = store && !mis && trans && hit && fault;
  exp_ptag_chk = req_v && (!trans || hit);
  exp_ptag     = '0;
  if (trans)
    exp_ptag = pte.ptag;
  else
    exp_ptag[`MEM_VTAG_WIDTH-1:0] = vtag;
endtask

// Edge update, flush beats a fill
task automatic model_update(input logic flush, input logic fill_v,
                            input logic [`MEM_VADDR_WIDTH-1:0] fill_vaddr,
                            input pte_leaf_s fill_pte);
  if (flush)
  begin
    for (int i = 0; i < `MEM_DTLB_ELS; i++)
      m_valid[i] = 1'b0;
    m_victim = 0;
  end
  else if (fill_v)
  begin
    m_valid[m_victim]      = 1'b1;
    m_entry[m_victim].vtag = fill_vaddr[`MEM_VADDR_WIDTH-1:`MEM_PAGE_OFFSET_WIDTH];
    m_entry[m_victim].pte  = fill_pte;
    m_victim               = (m_victim + 1) % `MEM_DTLB_ELS;
  end
endtask

`endif

//--- testbench/tb_mem_pipe.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_pipe_params.svh"

module tb_mem_pipe;

  import mem_op_pkg::*;
  import tlb_pkg::*;

  localparam int unsigned seed_lp = 32'h99a5;
  localparam int num_reqs_lp      = 2000;
  localparam int reset_cycles_lp  = 4;
  localparam int timeout_lp       = num_reqs_lp + reset_cycles_lp + 100;
  localparam int pool_size_lp     = 12;

  logic clk, reset;
  logic req_v, trans_en, priv_user, flush, fill_v;
  mem_op_e req_op;
  logic [`MEM_DWORD_WIDTH-1:0] rs1, imm;
  logic [`MEM_VADDR_WIDTH-1:0] fill_vaddr;
  pte_leaf_s fill_pte;
  logic early_v, ld_miss, st_miss, ld_mis, st_mis, ld_pf, st_pf;
  logic [`MEM_PTAG_WIDTH-1:0] ptag;

  logic [`MEM_VTAG_WIDTH-1:0] vtag_pool [pool_size_lp];
  int cycle_count = 0;

  `include "mem_pipe_model.svh"

  mem_pipe_top dut0
    (.clk_i(clk), .reset_i(reset), .req_v_i(req_v), .req_op_i(req_op)
     ,.rs1_i(rs1), .imm_i(imm), .trans_en_i(trans_en), .priv_user_i(priv_user)
     ,.flush_i(flush), .fill_v_i(fill_v), .fill_vaddr_i(fill_vaddr)
     ,.fill_pte_i(fill_pte), .early_v_o(early_v), .ptag_o(ptag)
     ,.tlb_load_miss_v_o(ld_miss), .tlb_store_miss_v_o(st_miss)
     ,.load_misaligned_v_o(ld_mis), .store_misaligned_v_o(st_mis)
     ,.load_page_fault_v_o(ld_pf), .store_page_fault_v_o(st_pf)
     );

  initial
    clk = 1'b0;
  always #4 clk = ~clk;

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_lp)
    begin
      $display("Timeout: no end of test after %0d cycles", timeout_lp);
      $display("Regression failed");
      $fatal(1, "simulation stopped by the cycle limit");
    end
  end

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
      $display("Regression failed");
      $fatal(1, "flag mismatch");
    end
  endtask

  task automatic check_ptag(input string name, input logic [`MEM_PTAG_WIDTH-1:0] exp,
                            input logic [`MEM_PTAG_WIDTH-1:0] act);
    if (act !== exp)
    begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      $display("Regression failed");
      $fatal(1, "physical tag mismatch");
    end
  endtask

  task automatic check_outputs(input int idx);
    string tag;
    tag = (idx < 0) ? "after_reset" : $sformatf("req_%0d", idx);
    check_flag({tag, " early_v"}, exp_early, early_v);
    check_flag({tag, " tlb_load_miss"}, exp_ld_miss, ld_miss);
    check_flag({tag, " tlb_store_miss"}, exp_st_miss, st_miss);
    check_flag({tag, " load_misaligned"}, exp_ld_mis, ld_mis);
    check_flag({tag, " store_misaligned"}, exp_st_mis, st_mis);
    check_flag({tag, " load_page_fault"}, exp_ld_pf, ld_pf);
    check_flag({tag, " store_page_fault"}, exp_st_pf, st_pf);
    if (exp_ptag_chk)
      check_ptag({tag, " ptag"}, exp_ptag, ptag);
  endtask

  // One random request plus optional fill and flush, driven at the falling edge
  task automatic drive_random_cycle();
    logic [`MEM_VADDR_WIDTH-1:0] vaddr;
    logic [`MEM_PAGE_OFFSET_WIDTH-1:0] offset;
    logic [11:0] imm12;
    logic [`MEM_DWORD_WIDTH-1:0] imm_val;
    offset = 12'($urandom);
    if ($urandom_range(3) != 0)
      offset[2:0] = 3'b000;
    vaddr   = {vtag_pool[$urandom_range(pool_size_lp - 1)], offset};
    imm12   = 12'($urandom);
    imm_val = {{52{imm12[11]}}, imm12};
    req_v     = ($urandom_range(7) != 0);
    req_op    = mem_op_e'(4'($urandom_range(10)));
    imm       = imm_val;
    rs1       = {25'($urandom), vaddr} - imm_val;
    trans_en  = ($urandom_range(7) != 0);
    priv_user = 1'($urandom);
    flush     = ($urandom_range(63) == 0);
    fill_v    = ($urandom_range(3) == 0);
    // Sometimes fill the very page being looked up
    if ($urandom_range(3) == 0)
      fill_vaddr = {vaddr[`MEM_VADDR_WIDTH-1:`MEM_PAGE_OFFSET_WIDTH], 12'($urandom)};
    else
      fill_vaddr = {vtag_pool[$urandom_range(pool_size_lp - 1)], 12'($urandom)};
    fill_pte.ptag = 28'($urandom);
    fill_pte.d    = 1'($urandom);
    fill_pte.a    = ($urandom_range(7) != 0);
    fill_pte.u    = 1'($urandom);
    fill_pte.w    = 1'($urandom);
    fill_pte.r    = ($urandom_range(3) != 0);
    model_predict(req_v, req_op, vaddr, trans_en, priv_user);
    model_update(flush, fill_v, fill_vaddr, fill_pte);
  endtask

  initial
  begin
    void'($urandom(seed_lp));
    for (int i = 0; i < pool_size_lp; i++)
      vtag_pool[i] = 27'($urandom);
    reset      = 1'b1;
    req_v      = 1'b0;
    req_op     = e_op_lb;
    rs1        = '0;
    imm        = '0;
    trans_en   = 1'b0;
    priv_user  = 1'b0;
    flush      = 1'b0;
    fill_v     = 1'b0;
    fill_vaddr = '0;
    fill_pte   = '0;
    model_reset();
    repeat (reset_cycles_lp) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    for (int n = 0; n < num_reqs_lp; n++)
    begin
      check_outputs(n - 1);
      drive_random_cycle();
      @(negedge clk);
    end
    check_outputs(num_reqs_lp - 1);
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- src/mem_pipe_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_pipe_params.svh"

module mem_pipe_top
  (input wire                          clk_i
   , input wire                        reset_i

   , input wire                        req_v_i
   , input wire mem_op_pkg::mem_op_e   req_op_i
   , input wire [`MEM_DWORD_WIDTH-1:0] rs1_i
   , input wire [`MEM_DWORD_WIDTH-1:0] imm_i

   , input wire                        trans_en_i
   , input wire                        priv_user_i

   , input wire                        flush_i
   , input wire                        fill_v_i
   , input wire [`MEM_VADDR_WIDTH-1:0] fill_vaddr_i
   , input wire tlb_pkg::pte_leaf_s    fill_pte_i

   , output logic                      early_v_o
   , output logic [`MEM_PTAG_WIDTH-1:0] ptag_o
   , output logic                      tlb_load_miss_v_o
   , output logic                      tlb_store_miss_v_o
   , output logic                      load_misaligned_v_o
   , output logic                      store_misaligned_v_o
   , output logic                      load_page_fault_v_o
   , output logic                      store_page_fault_v_o
   );

  import tlb_pkg::*;

  logic [`MEM_VADDR_WIDTH-1:0] vaddr;
  logic                        is_load, is_store, misaligned;
  logic [`MEM_DTLB_ELS-1:0]    way_hit;
  tlb_entry_s                  way_entries [`MEM_DTLB_ELS];
  logic                        tlb_hit;
  pte_leaf_s                   tlb_pte;

  tlb_bus_if dtlb_bus ();

  mem_agen agen
    (.rs1_i(rs1_i)
     ,.imm_i(imm_i)
     ,.op_i(req_op_i)
     ,.vaddr_o(vaddr)
     ,.is_load_o(is_load)
     ,.is_store_o(is_store)
     ,.misaligned_o(misaligned)
     );

  dtlb_fill_ctrl fill_ctrl
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.flush_i(flush_i)
     ,.fill_v_i(fill_v_i)
     ,.fill_vaddr_i(fill_vaddr_i)
     ,.fill_pte_i(fill_pte_i)
     ,.lookup_vaddr_i(vaddr)
     ,.bus_o(dtlb_bus.ctrl)
     );

  for (genvar i = 0; i < `MEM_DTLB_ELS; i++)
  begin : g_way
    dtlb_entry #(.way_p(i)) entry
      (.clk_i(clk_i)
       ,.reset_i(reset_i)
       ,.bus_i(dtlb_bus.entry)
       ,.hit_o(way_hit[i])
       ,.entry_o(way_entries[i])
       );
  end

  dtlb_match_sel match_sel
    (.hit_i(way_hit)
     ,.entries_i(way_entries)
     ,.hit_o(tlb_hit)
     ,.pte_o(tlb_pte)
     );

  mem_except_stage except_stage
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.req_v_i(req_v_i)
     ,.trans_en_i(trans_en_i)
     ,.priv_user_i(priv_user_i)
     ,.vaddr_i(vaddr)
     ,.is_load_i(is_load)
     ,.is_store_i(is_store)
     ,.misaligned_i(misaligned)
     ,.hit_i(tlb_hit)
     ,.pte_i(tlb_pte)
     ,.early_v_o(early_v_o)
     ,.tlb_load_miss_v_o(tlb_load_miss_v_o)
     ,.tlb_store_miss_v_o(tlb_store_miss_v_o)
     ,.load_misaligned_v_o(load_misaligned_v_o)
     ,.store_misaligned_v_o(store_misaligned_v_o)
     ,.load_page_fault_v_o(load_page_fault_v_o)
     ,.store_page_fault_v_o(store_page_fault_v_o)
     ,.ptag_o(ptag_o)
     );

endmodule

`default_nettype wire

//--- src/mem_except_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_pipe_params.svh"

module mem_except_stage
  (input wire                          clk_i
   , input wire                        reset_i

   , input wire                        req_v_i
   , input wire                        trans_en_i
   , input wire                        priv_user_i
   , input wire [`MEM_VADDR_WIDTH-1:0] vaddr_i
   , input wire                        is_load_i
   , input wire                        is_store_i
   , input wire                        misaligned_i
   , input wire                        hit_i
   , input wire tlb_pkg::pte_leaf_s    pte_i

   , output logic                      early_v_o
   , output logic                      tlb_load_miss_v_o
   , output logic                      tlb_store_miss_v_o
   , output logic                      load_misaligned_v_o
   , output logic                      store_misaligned_v_o
   , output logic                      load_page_fault_v_o
   , output logic                      store_page_fault_v_o
   , output logic [`MEM_PTAG_WIDTH-1:0] ptag_o
   );

  logic load_req, store_req;
  logic xlate, miss, perm_hit;
  logic base_fault, load_fault, store_fault;

  assign load_req  = req_v_i & is_load_i;
  assign store_req = req_v_i & is_store_i;

  // Misalignment masks the translation result
  assign xlate    = trans_en_i & ~misaligned_i;
  assign miss     = xlate & ~hit_i;
  assign perm_hit = xlate & hit_i;

  // User pages only from user mode, supervisor pages only from supervisor
  assign base_fault  = ~pte_i.a | (priv_user_i ^ pte_i.u);
  assign load_fault  = base_fault | ~pte_i.r;
  assign store_fault = base_fault | ~pte_i.w | ~pte_i.d;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      early_v_o            <= 1'b0;
      tlb_load_miss_v_o    <= 1'b0;
      tlb_store_miss_v_o   <= 1'b0;
      load_misaligned_v_o  <= 1'b0;
      store_misaligned_v_o <= 1'b0;
      load_page_fault_v_o  <= 1'b0;
      store_page_fault_v_o <= 1'b0;
    end
    else
    begin
      early_v_o            <= req_v_i;
      tlb_load_miss_v_o    <= load_req & miss;
      tlb_store_miss_v_o   <= store_req & miss;
      load_misaligned_v_o  <= load_req & misaligned_i;
      store_misaligned_v_o <= store_req & misaligned_i;
      load_page_fault_v_o  <= load_req & perm_hit & load_fault;
      store_page_fault_v_o <= store_req & perm_hit & store_fault;
    end
  end

  // Bare mode passes the virtual page number through
  always_ff @(posedge clk_i)
  begin
    if (req_v_i)
      ptag_o <= trans_en_i
                ? pte_i.ptag
                : {{(`MEM_PTAG_WIDTH - `MEM_VTAG_WIDTH){1'b0}},
                   vaddr_i[`MEM_VADDR_WIDTH-1:`MEM_PAGE_OFFSET_WIDTH]};
  end

endmodule

`default_nettype wire

//--- src/dtlb_match_sel.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_pipe_params.svh"

module dtlb_match_sel
  (input wire [`MEM_DTLB_ELS-1:0] hit_i
   , input wire tlb_pkg::tlb_entry_s entries_i [`MEM_DTLB_ELS]

   , output logic                  hit_o
   , output tlb_pkg::pte_leaf_s    pte_o
   );

  import tlb_pkg::*;

  pte_leaf_s pte_sel;

  // Duplicate tags are possible, the lowest way wins
  always_comb
  begin
    pte_sel = '0;
    for (int i = `MEM_DTLB_ELS - 1; i >= 0; i--)
    begin
      if (hit_i[i])
        pte_sel = entries_i[i].pte;
    end
  end

  assign hit_o = |hit_i;
  assign pte_o = pte_sel;

endmodule

`default_nettype wire

//--- src/dtlb_entry.sv
`timescale 1ns/1ns
`default_nettype none

module dtlb_entry
  #(parameter int way_p = 0)
  (input wire                     clk_i
   , input wire                   reset_i

   , tlb_bus_if.entry             bus_i

   , output logic                 hit_o
   , output tlb_pkg::tlb_entry_s  entry_o
   );

  import tlb_pkg::*;

  logic       valid_r;
  tlb_entry_s entry_r;
  logic       wr_en;

  // Flush takes priority over a fill in the same cycle
  assign wr_en = bus_i.w_v & bus_i.w_way[way_p] & ~bus_i.flush;

  always_ff @(posedge clk_i)
  begin
    if (reset_i | bus_i.flush)
      valid_r <= 1'b0;
    else if (wr_en)
      valid_r <= 1'b1;
  end

  always_ff @(posedge clk_i)
  begin
    if (wr_en)
      entry_r <= bus_i.w_entry;
  end

  assign hit_o   = valid_r & (entry_r.vtag == bus_i.r_vtag);
  assign entry_o = entry_r;

endmodule

`default_nettype wire

//--- src/dtlb_fill_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_pipe_params.svh"

module dtlb_fill_ctrl
  (input wire                           clk_i
   , input wire                         reset_i

   , input wire                         flush_i
   , input wire                         fill_v_i
   , input wire [`MEM_VADDR_WIDTH-1:0]  fill_vaddr_i
   , input wire tlb_pkg::pte_leaf_s     fill_pte_i

   , input wire [`MEM_VADDR_WIDTH-1:0]  lookup_vaddr_i

   , tlb_bus_if.ctrl                    bus_o
   );

  import tlb_pkg::*;

  logic [`MEM_DTLB_IDX_WIDTH-1:0] victim_r;
  tlb_entry_s                     fill_entry;

  // Round-robin victim, restarts at way 0 after a flush
  always_ff @(posedge clk_i)
  begin
    if (reset_i | flush_i)
      victim_r <= '0;
    else if (fill_v_i)
    begin
      if (victim_r == `MEM_DTLB_IDX_WIDTH'(`MEM_DTLB_ELS - 1))
        victim_r <= '0;
      else
        victim_r <= victim_r + 1'b1;
    end
  end

  assign fill_entry.vtag = fill_vaddr_i[`MEM_VADDR_WIDTH-1:`MEM_PAGE_OFFSET_WIDTH];
  assign fill_entry.pte  = fill_pte_i;

  assign bus_o.r_vtag  = lookup_vaddr_i[`MEM_VADDR_WIDTH-1:`MEM_PAGE_OFFSET_WIDTH];
  assign bus_o.w_v     = fill_v_i;
  assign bus_o.w_entry = fill_entry;
  assign bus_o.w_way   = `MEM_DTLB_ELS'(1) << victim_r;
  assign bus_o.flush   = flush_i;

endmodule

`default_nettype wire

//--- src/mem_agen.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_pipe_params.svh"

module mem_agen
  (input wire [`MEM_DWORD_WIDTH-1:0]   rs1_i
   , input wire [`MEM_DWORD_WIDTH-1:0] imm_i
   , input wire mem_op_pkg::mem_op_e   op_i

   , output logic [`MEM_VADDR_WIDTH-1:0] vaddr_o
   , output logic                        is_load_o
   , output logic                        is_store_o
   , output logic                        misaligned_o
   );

  import mem_op_pkg::*;

  logic [`MEM_DWORD_WIDTH-1:0] eaddr;
  mem_size_e                   size;

  assign eaddr   = rs1_i + imm_i;
  assign vaddr_o = eaddr[`MEM_VADDR_WIDTH-1:0];

  always_comb
  begin
    case (op_i)
      e_op_lb, e_op_lbu, e_op_sb: size = e_size_byte;
      e_op_lh, e_op_lhu, e_op_sh: size = e_size_half;
      e_op_lw, e_op_lwu, e_op_sw: size = e_size_word;
      default:                    size = e_size_dword;
    endcase
  end

  assign is_load_o  = op_i inside {e_op_lb, e_op_lbu, e_op_lh, e_op_lhu,
                                   e_op_lw, e_op_lwu, e_op_ld};
  assign is_store_o = op_i inside {e_op_sb, e_op_sh, e_op_sw, e_op_sd};

  // Low address bits must be clear up to the access size
  always_comb
  begin
    case (size)
      e_size_half:  misaligned_o = eaddr[0];
      e_size_word:  misaligned_o = |eaddr[1:0];
      e_size_dword: misaligned_o = |eaddr[2:0];
      default:      misaligned_o = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- src/tlb_bus_if.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_pipe_params.svh"

interface tlb_bus_if;

  import tlb_pkg::*;

  // Lookup side
  logic [`MEM_VTAG_WIDTH-1:0] r_vtag;

  // Fill and flush side
  logic                       w_v;
  tlb_entry_s                 w_entry;
  logic [`MEM_DTLB_ELS-1:0]   w_way;
  logic                       flush;

  modport ctrl
    (output r_vtag
     , output w_v
     , output w_entry
     , output w_way
     , output flush
     );

  modport entry
    (input r_vtag
     , input w_v
     , input w_entry
     , input w_way
     , input flush
     );

endinterface

`default_nettype wire

//--- src/tlb_pkg.sv
`default_nettype none

`include "mem_pipe_params.svh"

package tlb_pkg;

  // Leaf PTE as kept in the TLB
  typedef struct packed
  {
    logic [`MEM_PTAG_WIDTH-1:0] ptag;
    logic                       d;
    logic                       a;
    logic                       u;
    logic                       w;
    logic                       r;
  } pte_leaf_s;

  typedef struct packed
  {
    logic [`MEM_VTAG_WIDTH-1:0] vtag;
    pte_leaf_s                  pte;
  } tlb_entry_s;

endpackage

`default_nettype wire

//--- src/mem_op_pkg.sv
`default_nettype none

package mem_op_pkg;

  // Integer load and store opcodes
  typedef enum logic [3:0]
  {
    e_op_lb  = 4'd0,
    e_op_lbu = 4'd1,
    e_op_lh  = 4'd2,
    e_op_lhu = 4'd3,
    e_op_lw  = 4'd4,
    e_op_lwu = 4'd5,
    e_op_ld  = 4'd6,
    e_op_sb  = 4'd7,
    e_op_sh  = 4'd8,
    e_op_sw  = 4'd9,
    e_op_sd  = 4'd10
  } mem_op_e;

  // Access size, log2 of the byte count
  typedef enum logic [1:0]
  {
    e_size_byte  = 2'b00,
    e_size_half  = 2'b01,
    e_size_word  = 2'b10,
    e_size_dword = 2'b11
  } mem_size_e;

endpackage

`default_nettype wire

//--- include/mem_pipe_params.svh
`ifndef MEM_PIPE_PARAMS_SVH
`define MEM_PIPE_PARAMS_SVH

// Datapath and address widths
`define MEM_DWORD_WIDTH        64
`define MEM_VADDR_WIDTH        39
`define MEM_PAGE_OFFSET_WIDTH  12

// Sv39 page tags
`define MEM_VTAG_WIDTH         27
`define MEM_PTAG_WIDTH         28

// Data TLB geometry
`define MEM_DTLB_ELS           8
`define MEM_DTLB_IDX_WIDTH     3

`endif
